//--- Makefile
# Verilator build and run for the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/control_unit.sv
hdl/imm_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/program_counter.sv
hdl/cpu.sv
tb/tb_cpu.sv

//--- hdl/alu.sv
// arithmetic logic unit
// operand muxes, rv32i operations, less and zero flags
`timescale 1ns/100ps

module alu (
    input  rv_ctrl_pkg::alu_op_e      alu_op,
    input  rv_ctrl_pkg::alu_a_sel_e   a_sel,
    input  rv_ctrl_pkg::alu_b_sel_e   b_sel,
    input  rv_isa_pkg::word_t         rs1_data,
    input  rv_isa_pkg::word_t         rs2_data,
    input  rv_isa_pkg::word_t         pc,
    input  rv_isa_pkg::word_t         imm,
    output rv_isa_pkg::word_t         result,
    output logic                      less,
    output logic                      zero
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t      a;
    word_t      b;
    logic [4:0] shamt;

    // operand a, rs1 or pc (auipc, links)
    assign a = (a_sel == alu_a_pc) ? pc : rs1_data;

    // operand b
    always_comb begin
        case (b_sel)
            alu_b_imm:  b = imm;
            alu_b_four: b = 32'd4;
            default:    b = rs2_data;
        endcase
    end

    // only the low five bits shift
    assign shamt = b[4:0];

    // unsigned for sltu, signed otherwise
    assign less = (alu_op == sltu) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (alu_op)
            add:     result = a + b;
            sub:     result = a - b;
            sll:     result = a << shamt;
            slt:     result = {31'b0, less};
            sltu:    result = {31'b0, less};
            xor_op:  result = a ^ b;
            srl:     result = a >> shamt;
            sra:     result = $signed(a) >>> shamt;
            or_op:   result = a | b;
            and_op:  result = a & b;
            pass_b:  result = b;
            default: result = '0;
        endcase
    end

    // equality test for beq/bne via sub
    assign zero = (result == '0);

endmodule

//--- hdl/control_unit.sv
// instruction decoder
// operand selects, alu op, write enable, branch resolution
`timescale 1ns/100ps

module control_unit (
    input  rv_isa_pkg::opcode_t       opcode,
    input  rv_isa_pkg::funct3_t       funct3,
    input  logic                      funct7_5,
    input  logic                      less,
    input  logic                      zero,
    output rv_ctrl_pkg::imm_fmt_e     imm_fmt,
    output logic                      reg_wen,
    output rv_ctrl_pkg::alu_op_e      alu_op,
    output rv_ctrl_pkg::alu_a_sel_e   alu_a_sel,
    output rv_ctrl_pkg::alu_b_sel_e   alu_b_sel,
    output rv_ctrl_pkg::pc_a_sel_e    pc_a_sel,
    output rv_ctrl_pkg::pc_b_sel_e    pc_b_sel,
    output logic                      jalr
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic taken;

    // funct3 to alu op, shared by OP and OP-IMM
    function automatic alu_op_e arith_op(input funct3_t f3, input logic sub_en,
                                         input logic sra_en);
        alu_op_e op;
        case (f3)
            f3_add_sub: op = sub_en ? sub : add;
            f3_sll:     op = sll;
            f3_slt:     op = slt;
            f3_sltu:    op = sltu;
            f3_xor:     op = xor_op;
            f3_srl_sra: op = sra_en ? sra : srl;
            f3_or:      op = or_op;
            default:    op = and_op;
        endcase
        return op;
    endfunction

    // branch compare op, eq/ne need the sub result for zero
    function automatic alu_op_e branch_op(input funct3_t f3);
        alu_op_e op;
        case (f3)
            f3_blt, f3_bge:   op = slt;
            f3_bltu, f3_bgeu: op = sltu;
            default:          op = sub;
        endcase
        return op;
    endfunction

    // condition from alu flags
    always_comb begin
        case (funct3)
            f3_beq:           taken = zero;
            f3_bne:           taken = !zero;
            f3_blt, f3_bltu:  taken = less;
            f3_bge, f3_bgeu:  taken = !less;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        // no-op defaults, pc + 4 and no write
        imm_fmt   = imm_i;
        reg_wen   = 1'b0;
        alu_op    = add;
        alu_a_sel = alu_a_rs1;
        alu_b_sel = alu_b_rs2;
        pc_a_sel  = pc_a_four;
        pc_b_sel  = pc_b_pc;
        jalr      = 1'b0;
        case (opcode)
            opc_op: begin
                reg_wen = 1'b1;
                alu_op  = arith_op(funct3, funct7_5, funct7_5);
            end
            opc_op_imm: begin
                // sub never comes from an immediate
                reg_wen   = 1'b1;
                alu_b_sel = alu_b_imm;
                alu_op    = arith_op(funct3, 1'b0, funct7_5);
            end
            opc_lui: begin
                imm_fmt   = imm_u;
                reg_wen   = 1'b1;
                alu_op    = pass_b;
                alu_b_sel = alu_b_imm;
            end
            opc_auipc: begin
                imm_fmt   = imm_u;
                reg_wen   = 1'b1;
                alu_a_sel = alu_a_pc;
                alu_b_sel = alu_b_imm;
            end
            opc_jal: begin
                // link value pc + 4 through the alu
                imm_fmt   = imm_j;
                reg_wen   = 1'b1;
                alu_a_sel = alu_a_pc;
                alu_b_sel = alu_b_four;
                pc_a_sel  = pc_a_imm;
            end
            opc_jalr: begin
                reg_wen   = 1'b1;
                alu_a_sel = alu_a_pc;
                alu_b_sel = alu_b_four;
                pc_a_sel  = pc_a_imm;
                pc_b_sel  = pc_b_rs1;
                jalr      = 1'b1;
            end
            opc_branch: begin
                imm_fmt  = imm_b;
                alu_op   = branch_op(funct3);
                pc_a_sel = taken ? pc_a_imm : pc_a_four;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/cpu.sv
// single-cycle rv32i core top level
// field extraction and the five datapath and control blocks
`timescale 1ns/100ps

module cpu (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_isa_pkg::word_t       cmd,
    output rv_isa_pkg::word_t       pc,
    output logic                    wb_en,
    output rv_isa_pkg::reg_addr_t   wb_addr,
    output rv_isa_pkg::word_t       wb_data
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // instruction fields
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    opcode_t   opcode;
    funct3_t   funct3;
    logic      funct7_5;

    // datapath
    word_t rs1_data;
    word_t rs2_data;
    word_t imm;
    word_t alu_result;
    logic  less;
    logic  zero;

    // control
    imm_fmt_e   imm_fmt;
    logic       reg_wen;
    alu_op_e    alu_op;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    pc_a_sel_e  pc_a_sel;
    pc_b_sel_e  pc_b_sel;
    logic       jalr;

    assign opcode   = cmd[6:0];
    assign rd       = cmd[11:7];
    assign funct3   = cmd[14:12];
    assign rs1      = cmd[19:15];
    assign rs2      = cmd[24:20];
    assign funct7_5 = cmd[30];

    // trace of the register write
    assign wb_en   = reg_wen;
    assign wb_addr = rd;
    assign wb_data = alu_result;

    control_unit i_control_unit (
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7_5  (funct7_5),
        .less      (less),
        .zero      (zero),
        .imm_fmt   (imm_fmt),
        .reg_wen   (reg_wen),
        .alu_op    (alu_op),
        .alu_a_sel (alu_a_sel),
        .alu_b_sel (alu_b_sel),
        .pc_a_sel  (pc_a_sel),
        .pc_b_sel  (pc_b_sel),
        .jalr      (jalr)
    );

    imm_decoder i_imm_decoder (
        .cmd     (cmd),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    register_file i_register_file (
        .clk     (clk),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (rd),
        .wdata   (alu_result),
        .wen     (reg_wen),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    alu i_alu (
        .alu_op   (alu_op),
        .a_sel    (alu_a_sel),
        .b_sel    (alu_b_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .imm      (imm),
        .result   (alu_result),
        .less     (less),
        .zero     (zero)
    );

    program_counter i_program_counter (
        .clk      (clk),
        .reset    (reset),
        .a_sel    (pc_a_sel),
        .b_sel    (pc_b_sel),
        .jalr     (jalr),
        .imm      (imm),
        .rs1_data (rs1_data),
        .pc       (pc)
    );

endmodule

//--- hdl/imm_decoder.sv
// immediate decoder
// sign-extended i, s, b, u and j immediates
`timescale 1ns/100ps

module imm_decoder (
    input  rv_isa_pkg::word_t      cmd,
    input  rv_ctrl_pkg::imm_fmt_e  imm_fmt,
    output rv_isa_pkg::word_t      imm
);
    import rv_ctrl_pkg::*;

    // bit 31 is the sign for every format
    always_comb begin
        case (imm_fmt)
            imm_i: imm = {{20{cmd[31]}}, cmd[31:20]};
            imm_s: imm = {{20{cmd[31]}}, cmd[31:25], cmd[11:7]};
            // b and j drop bit 0, offsets stay even
            imm_b: imm = {{19{cmd[31]}}, cmd[31], cmd[7], cmd[30:25],
                          cmd[11:8], 1'b0};
            imm_j: imm = {{11{cmd[31]}}, cmd[31], cmd[19:12], cmd[20],
                          cmd[30:21], 1'b0};
            // upper 20 bits, low bits zero
            imm_u: imm = {cmd[31:12], 12'h000};
            default: imm = '0;
        endcase
    end

endmodule

//--- hdl/program_counter.sv
// program counter
// next-pc adder, jalr bit-0 clear, pc register
`timescale 1ns/100ps

module program_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  rv_ctrl_pkg::pc_a_sel_e   a_sel,
    input  rv_ctrl_pkg::pc_b_sel_e   b_sel,
    input  logic                     jalr,
    input  rv_isa_pkg::word_t        imm,
    input  rv_isa_pkg::word_t        rs1_data,
    output rv_isa_pkg::word_t        pc
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t step;
    word_t base;
    word_t sum;
    word_t next_pc;

    // step four or immediate, base pc or rs1
    assign step = (a_sel == pc_a_imm) ? imm : 32'd4;
    assign base = (b_sel == pc_b_rs1) ? rs1_data : pc;
    assign sum  = base + step;

    // jalr target has bit 0 cleared
    assign next_pc = jalr ? {sum[31:1], 1'b0} : sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else begin
            pc <= next_pc;
        end
    end

    // aligned programs only, targets from decoder and alu must keep this
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

//--- hdl/register_file.sv
// integer register file
// two combinational read ports, one clocked write port, x0 tied to zero
`timescale 1ns/100ps

module register_file (
    input  logic                    clk,
    input  rv_isa_pkg::reg_addr_t   raddr_a,
    input  rv_isa_pkg::reg_addr_t   raddr_b,
    input  rv_isa_pkg::reg_addr_t   waddr,
    input  rv_isa_pkg::word_t       wdata,
    input  logic                    wen,
    output rv_isa_pkg::word_t       rdata_a,
    output rv_isa_pkg::word_t       rdata_b
);
    import rv_isa_pkg::*;

    // x1..x31 only, x0 has no storage
    word_t regs [1:num_regs-1];

    // writes to x0 dropped
    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // contents not reset
    // a read before the first write reaches the write port as unknown data
    assert property (@(posedge clk) wen |-> !$isunknown({waddr, wdata}))
        else $error("register write with unknown address or data");

endmodule

//--- hdl/rv_ctrl_pkg.sv
// datapath control encodings
// alu operations, immediate formats, operand selects, reset vector
package rv_ctrl_pkg;

    // alu operation, pass_b forwards operand b (lui)
    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        sll    = 4'd2,
        slt    = 4'd3,
        sltu   = 4'd4,
        xor_op = 4'd5,
        srl    = 4'd6,
        sra    = 4'd7,
        or_op  = 4'd8,
        and_op = 4'd9,
        pass_b = 4'd10
    } alu_op_e;

    // immediate layout in the instruction word
    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_fmt_e;

    // alu operand a
    typedef enum logic {
        alu_a_rs1 = 1'b0,
        alu_a_pc  = 1'b1
    } alu_a_sel_e;

    // alu operand b
    typedef enum logic [1:0] {
        alu_b_rs2  = 2'b00,
        alu_b_imm  = 2'b01,
        alu_b_four = 2'b10
    } alu_b_sel_e;

    // next pc step and base
    typedef enum logic {
        pc_a_four = 1'b0,
        pc_a_imm  = 1'b1
    } pc_a_sel_e;

    typedef enum logic {
        pc_b_pc  = 1'b0,
        pc_b_rs1 = 1'b1
    } pc_b_sel_e;

    // first fetch address
    localparam logic [31:0] reset_vector = 32'h0000_0000;

endpackage

//--- hdl/rv_isa_pkg.sv
// rv32i instruction set definitions
// word and field types, major opcodes, funct3 codes
package rv_isa_pkg;

    // field widths
    localparam int xlen      = 32;
    localparam int reg_bits  = 5;
    localparam int num_regs  = 32;

    typedef logic [xlen-1:0]     word_t;
    typedef logic [reg_bits-1:0] reg_addr_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;

    // major opcodes, only the groups this core runs
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_lui    = 7'b0110111;
    localparam opcode_t opc_auipc  = 7'b0010111;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;
    localparam opcode_t opc_branch = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // funct3 for conditional branches
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

endpackage

//--- tb/cpu_patterns.txt
// columns: pc, instruction, wb_en, wb_addr, wb_data, next pc (all hex)
// one line per executed instruction, pc starts at 0
00000000 ffb00093 1 01 fffffffb 00000004 // addi x1, x0, -5
00000004 00700113 1 02 00000007 00000008 // addi x2, x0, 7
00000008 0030a193 1 03 00000001 0000000c // slti x3, x1, 3
0000000c 0030b213 1 04 00000000 00000010 // sltiu x4, x1, 3
00000010 0f00c293 1 05 ffffff0b 00000014 // xori x5, x1, 0xf0
00000014 f0016313 1 06 ffffff07 00000018 // ori x6, x2, -256
00000018 7ff0f393 1 07 000007fb 0000001c // andi x7, x1, 0x7ff
0000001c 01411413 1 08 00700000 00000020 // slli x8, x2, 20
00000020 0110d493 1 09 00007fff 00000024 // srli x9, x1, 17
00000024 4110d513 1 0a ffffffff 00000028 // srai x10, x1, 17
00000028 002085b3 1 0b 00000002 0000002c // add x11, x1, x2
0000002c 40208633 1 0c fffffff4 00000030 // sub x12, x1, x2
00000030 009116b3 1 0d 80000000 00000034 // sll x13, x2, x9 (shift 31)
00000034 0026a733 1 0e 00000001 00000038 // slt x14, x13, x2
00000038 0026b7b3 1 0f 00000000 0000003c // sltu x15, x13, x2
0000003c 0062c833 1 10 0000000c 00000040 // xor x16, x5, x6
00000040 010658b3 1 11 000fffff 00000044 // srl x17, x12, x16
00000044 4096d933 1 12 ffffffff 00000048 // sra x18, x13, x9
00000048 0083e9b3 1 13 007007fb 0000004c // or x19, x7, x8
0000004c 0132fa33 1 14 0070070b 00000050 // and x20, x5, x19
00000050 00208033 1 00 00000002 00000054 // add x0, x1, x2
00000054 00200ab3 1 15 00000007 00000058 // add x21, x0, x2, x0 still zero
00000058 00000000 0 00 00000000 0000005c // all zero, undecoded
0000005c 00100073 0 00 00000000 00000060 // ebreak, undecoded
00000060 80001b37 1 16 80001000 00000064 // lui x22, 0x80001
00000064 12345b97 1 17 12345064 00000068 // auipc x23, 0x12345
00000068 01510463 0 00 00000000 00000070 // beq x2, x21, +8 taken
00000070 00208463 0 00 00000000 00000074 // beq x1, x2, +8 not taken
00000074 00209463 0 00 00000000 0000007c // bne x1, x2, +8 taken
0000007c 01511463 0 00 00000000 00000080 // bne x2, x21, +8 not taken
00000080 0020c463 0 00 00000000 00000088 // blt x1, x2, +8 taken
00000088 0020e463 0 00 00000000 0000008c // bltu x1, x2, +8 not taken
0000008c 0020d463 0 00 00000000 00000090 // bge x1, x2, +8 not taken
00000090 0020f463 0 00 00000000 00000098 // bgeu x1, x2, +8 taken
00000098 00116463 0 00 00000000 000000a0 // bltu x2, x1, +8 taken
000000a0 00114463 0 00 00000000 000000a4 // blt x2, x1, +8 not taken
000000a4 00115463 0 00 00000000 000000ac // bge x2, x1, +8 taken
000000ac 00117463 0 00 00000000 000000b0 // bgeu x2, x1, +8 not taken
000000b0 0c800d13 1 1a 000000c8 000000b4 // addi x26, x0, 0xc8
000000b4 01000c6f 1 18 000000b8 000000c4 // jal x24, +16
000000c4 fe259ce3 0 00 00000000 000000bc // bne x11, x2, -8 backward taken
000000bc 009d0ce7 1 19 000000c0 000000d0 // jalr x25, 9(x26), sum 0xd1
000000d0 019c0db3 1 1b 00000178 000000d4 // add x27, x24, x25
000000d4 0000000b 0 00 00000000 000000d8 // custom-0, undecoded

//--- tb/tb_cpu.sv
// testbench for the single-cycle rv32i core
// replays the pattern file as an instruction stream
// checks pc, next pc and the writeback trace of every record
`timescale 1ns/100ps

module tb_cpu;
    import rv_isa_pkg::*;

    localparam string pattern_file = "tb/cpu_patterns.txt";
    localparam int    max_records  = 64;
    localparam int    fields       = 6;
    localparam int    drive_delay  = 1;
    localparam int    settle_delay = 1;

    // field positions inside one record
    localparam int f_pc      = 0;
    localparam int f_instr   = 1;
    localparam int f_wb_en   = 2;
    localparam int f_wb_addr = 3;
    localparam int f_wb_data = 4;
    localparam int f_next_pc = 5;

    logic      clk;
    logic      reset;
    word_t     cmd;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    word_t patterns [0:max_records*fields-1];
    int    num_records = 0;
    int    cur_record  = -1;
    int    checks      = 0;
    int    mismatches  = 0;
    int    faults      = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    cpu i_cpu (
        .clk     (clk),
        .reset   (reset),
        .cmd     (cmd),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // marker for slots the file did not fill, unique per index
    function automatic word_t fill_value(input int index);
        return word_t'(32'hfeed_0000 ^ index);
    endfunction

    function automatic word_t field(input int rec, input int pos);
        return patterns[rec*fields + pos];
    endfunction

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED %s: got %h, expected %h (record %0d)",
                     name, actual, expected, cur_record);
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t actual,
                                  input reg_addr_t expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED %s: got %h, expected %h (record %0d)",
                     name, actual, expected, cur_record);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED %s: got %h, expected %h (record %0d)",
                     name, actual, expected, cur_record);
        end
    endtask

    // count records, reject partial or out of range ones
    task automatic scan_patterns();
        int r;
        int k;
        while (num_records < max_records &&
               field(num_records, f_pc) !== fill_value(num_records*fields)) begin
            num_records++;
        end
        if (num_records == 0) begin
            faults++;
            $display("no records could be read from %s", pattern_file);
        end
        for (r = 0; r < num_records; r++) begin
            for (k = 0; k < fields; k++) begin
                if (field(r, k) === fill_value(r*fields + k)) begin
                    faults++;
                    $display("pattern record %0d is missing field %0d", r, k);
                end
            end
            if (field(r, f_wb_en) > 1 || field(r, f_wb_addr) >= num_regs) begin
                faults++;
                $display("pattern record %0d has an invalid wb_en or wb_addr field", r);
            end
        end
    endtask

    // one instruction in, trace compared once settled
    task automatic apply_record(input int r);
        cur_record = r;
        cmd = field(r, f_instr);
        #settle_delay;
        check_word("pc", pc, field(r, f_pc));
        check_bit("wb_en", wb_en, field(r, f_wb_en) != 0);
        if (field(r, f_wb_en) != 0) begin
            check_reg_addr("wb_addr", wb_addr, reg_addr_t'(field(r, f_wb_addr)));
            check_word("wb_data", wb_data, field(r, f_wb_data));
        end
    endtask

    initial begin
        int i;
        int r;
        reset = 1'b1;
        cmd   = '0;
        for (i = 0; i < max_records*fields; i++) begin
            patterns[i] = fill_value(i);
        end
        $readmemh(pattern_file, patterns);
        scan_patterns();
        cycle_limit = 2 * num_records + 20;

        // three edges of reset, cmd zero decodes as a no-op
        repeat (3) @(posedge clk);
        #drive_delay;
        check_word("pc", pc, 32'h0000_0000);
        check_bit("wb_en", wb_en, 1'b0);
        reset = 1'b0;

        for (r = 0; r < num_records; r++) begin
            if (r > 0) begin
                @(posedge clk);
                #drive_delay;
                cur_record = r - 1;
                check_word("next pc", pc, field(r - 1, f_next_pc));
            end
            apply_record(r);
        end
        @(posedge clk);
        #drive_delay;
        if (num_records > 0) begin
            cur_record = num_records - 1;
            check_word("next pc", pc, field(num_records - 1, f_next_pc));
        end

        $display("checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, faults);
        if (mismatches == 0 && faults == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // stops a run that goes past the expected length
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("checks: %0d, mismatches: %0d, other errors: %0d",
                     checks, mismatches, faults);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule
